/* hw/msi_bus_pkg.sv */
`default_nettype none

// register port view of the controller
package msi_bus_pkg;

	typedef logic [7:0]  reg_adr_t;	// word address
	typedef logic [31:0] reg_dat_t;	// data word

	// ============================================================
	// register map
	// ============================================================
	localparam reg_adr_t REG_CTRL      = 8'h00;	// bit 0 global enable
	localparam reg_adr_t REG_THRESH    = 8'h01;	// bits 2:0 priority threshold
	localparam reg_adr_t REG_EMPTY     = 8'h02;	// queue non-empty mask, read only
	localparam reg_adr_t REG_OVFL      = 8'h03;	// sticky overflow, write 1 to clear

	// pending bits, two words for 64 vectors, write 1 to clear
	localparam reg_adr_t REG_PEND_BASE = 8'h04;

	// vector table from here up
	// even word is the handler address, odd word the flags
	localparam reg_adr_t REG_VTBL_BASE = 8'h80;

endpackage

`default_nettype wire

/* hw/msi_irq_pkg.sv */
`default_nettype none

// interrupt message and vector table layout
package msi_irq_pkg;

	localparam int NVEC = 64;	// vectors per core
	localparam int NPRI = 8;	// priority levels, 0 is never queued

	typedef logic [5:0] vec_t;
	typedef logic [2:0] pri_t;

	typedef logic [NPRI-1:0] pri_mask_t;	// one bit per priority queue

	// one snooped message as held in a queue
	typedef struct packed {
		pri_t pri;
		vec_t vec;
	} msi_msg_t;

	// ============================================================
	// vector table entry
	// ============================================================
	// flags live in the upper word, handler in the lower
	typedef struct packed {
		logic [27:0] rsvd;	// reads back as written
		logic [2:0]  swstk;	// stack selector for the handler
		logic        ie;	// vector enable
		logic [31:0] handler;	// handler address
	} vte_fields_t;

	// same 64 bits seen as two register words, raw[0] is the even word
	typedef union packed {
		vte_fields_t                  f;
		msi_bus_pkg::reg_dat_t [1:0] raw;
	} vte_t;

endpackage

`default_nettype wire

/* hw/msi_que_if.sv */
`timescale 1ns/1ps
`default_nettype none

// queue bank to dispatcher link
interface msi_que_if;
	import msi_irq_pkg::*;

	pri_mask_t nonempty;	// one bit per queue holding a message
	logic      pop;	// take the head of queue pop_pri
	pri_t      pop_pri;	// queue being looked at
	msi_msg_t  head;	// head of queue pop_pri

	// queue bank side
	modport source (
		output nonempty, head,
		input  pop, pop_pri
	);

	// dispatcher side
	modport sink (
		input  nonempty, head,
		output pop, pop_pri
	);

	// status readout only
	modport monitor (input nonempty);

endinterface

`default_nettype wire

/* hw/msi_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module msi_regs (
	input  wire                           clk,
	input  wire                           rst,
	// register port
	input  wire                           reg_cs_i,
	input  wire                           reg_we_i,
	input  wire msi_bus_pkg::reg_adr_t    reg_adr_i,
	input  wire msi_bus_pkg::reg_dat_t    reg_dat_i,
	output msi_bus_pkg::reg_dat_t         reg_dat_o,
	output logic                          reg_ack_o,
	// intake events from the queue bank
	input  wire                           take_i,
	input  wire msi_irq_pkg::vec_t        take_vec_i,
	input  wire msi_irq_pkg::pri_mask_t   drop_i,
	msi_que_if.monitor                    que,
	// levels for the dispatcher
	output logic                          gen_o,
	output msi_irq_pkg::pri_t             thresh_o,
	// vector table access
	output logic                          tbl_we_o,
	output msi_bus_pkg::reg_adr_t         tbl_adr_o,
	output msi_bus_pkg::reg_dat_t         tbl_dat_o,
	input  wire msi_bus_pkg::reg_dat_t    tbl_dat_i
);
	import msi_bus_pkg::*;
	import msi_irq_pkg::*;

	logic            wr_stb, rd_stb;
	logic            is_vtbl, is_pend;
	logic [NVEC-1:0] pend_q;	// one bit per vector
	logic [NVEC-1:0] pend_set, pend_clr;
	pri_mask_t       ovfl_q, ovfl_clr;
	reg_dat_t        rd_mux;
	reg_dat_t        rd_dat_q;	// latched register read
	logic            rd_tbl_q;	// read in flight targets the table

	assign wr_stb  = reg_cs_i & reg_we_i;
	assign rd_stb  = reg_cs_i & ~reg_we_i;
	assign is_vtbl = reg_adr_i >= REG_VTBL_BASE;
	assign is_pend = reg_adr_i[7:1] == REG_PEND_BASE[7:1];	// two words

	// table accesses go straight through, the table decodes its own word
	assign tbl_we_o  = wr_stb & is_vtbl;
	assign tbl_adr_o = reg_adr_i;
	assign tbl_dat_o = reg_dat_i;

	// ============================================================
	// pending and overflow bits
	// ============================================================
	always_comb begin
		pend_set = '0;
		pend_clr = '0;
		ovfl_clr = '0;
		if (take_i)
			pend_set[take_vec_i] = 1'b1;	// set on every accepted message
		if (wr_stb && is_pend)
			pend_clr[{reg_adr_i[0], 5'd0} +: 32] = reg_dat_i;	// word 0 or 1
		if (wr_stb && reg_adr_i == REG_OVFL)
			ovfl_clr = reg_dat_i[NPRI-1:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			gen_o     <= 1'b0;
			thresh_o  <= '0;
			pend_q    <= '0;
			ovfl_q    <= '0;
			reg_ack_o <= 1'b0;
			rd_tbl_q  <= 1'b0;
		end else begin
			reg_ack_o <= reg_cs_i;	// one cycle after every strobe
			rd_tbl_q  <= rd_stb & is_vtbl;
			// a set in the same cycle beats the clear
			pend_q <= (pend_q & ~pend_clr) | pend_set;
			ovfl_q <= (ovfl_q & ~ovfl_clr) | drop_i;
			if (wr_stb && reg_adr_i == REG_CTRL)
				gen_o <= reg_dat_i[0];
			if (wr_stb && reg_adr_i == REG_THRESH)
				thresh_o <= reg_dat_i[2:0];
		end
	end

	// ============================================================
	// read path
	// ============================================================
	always_comb begin
		rd_mux = '0;
		if (is_pend)
			rd_mux = pend_q[{reg_adr_i[0], 5'd0} +: 32];
		else
			case (reg_adr_i)
			REG_CTRL:   rd_mux[0] = gen_o;
			REG_THRESH: rd_mux[2:0] = thresh_o;
			REG_EMPTY:  rd_mux[NPRI-1:0] = que.nonempty;	// live queue state
			REG_OVFL:   rd_mux[NPRI-1:0] = ovfl_q;
			default:    ;	// unmapped reads return zero
			endcase
	end

	always_ff @(posedge clk)
		if (rd_stb)
			rd_dat_q <= rd_mux;

	// table data arrives one cycle after the strobe, same as the ack
	assign reg_dat_o = rd_tbl_q ? tbl_dat_i : rd_dat_q;

endmodule

`default_nettype wire

/* hw/msi_queue_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module msi_queue_bank #(
	parameter logic [5:0] CORE_NO   = 6'd5,	// core this controller serves
	parameter int         QUE_DEPTH = 4	// entries per queue, power of two
) (
	input  wire                         clk,
	input  wire                         rst,
	// snooped message
	input  wire                         msg_valid_i,
	input  wire [5:0]                   msg_core_i,
	input  wire msi_irq_pkg::vec_t      msg_vec_i,
	input  wire msi_irq_pkg::pri_t      msg_pri_i,
	// events to the register block
	output logic                        take_o,
	output msi_irq_pkg::vec_t           take_vec_o,
	output msi_irq_pkg::pri_mask_t      drop_o,
	msi_que_if.source                   que
);
	import msi_irq_pkg::*;

	localparam int PW = $clog2(QUE_DEPTH);

	logic      accept;
	pri_mask_t full;
	pri_mask_t nonempty;
	msi_msg_t  in_msg;
	msi_msg_t  heads [NPRI];

	// ours, and not priority 0
	assign accept = msg_valid_i && msg_core_i == CORE_NO && msg_pri_i != '0;
	assign in_msg = '{pri: msg_pri_i, vec: msg_vec_i};

	assign take_o     = accept;	// pending bit is set even when dropped
	assign take_vec_o = msg_vec_i;
	assign drop_o     = accept ? (full & (pri_mask_t'(1) << msg_pri_i)) : '0;

	// priority 0 has no queue
	assign full[0]     = 1'b0;
	assign nonempty[0] = 1'b0;
	assign heads[0]    = '0;

	// ============================================================
	// one FIFO per priority
	// ============================================================
	for (genvar g = 1; g < NPRI; g++) begin : g_que
		msi_msg_t    mem [QUE_DEPTH];
		logic [PW:0] wp, rp;	// extra bit tells full from empty
		logic        push, pull;

		assign push = accept && msg_pri_i == pri_t'(g) && !full[g];
		assign pull = que.pop && que.pop_pri == pri_t'(g) && nonempty[g];

		assign full[g]     = wp[PW] != rp[PW] && wp[PW-1:0] == rp[PW-1:0];
		assign nonempty[g] = wp != rp;
		assign heads[g]    = mem[rp[PW-1:0]];

		always_ff @(posedge clk)
			if (push)
				mem[wp[PW-1:0]] <= in_msg;

		always_ff @(posedge clk) begin
			if (rst) begin
				wp <= '0;
				rp <= '0;
			end else begin
				if (push)
					wp <= wp + 1'b1;
				if (pull)
					rp <= rp + 1'b1;
			end
		end
	end

	assign que.nonempty = nonempty;
	assign que.head     = heads[que.pop_pri];	// head follows the select

endmodule

`default_nettype wire

/* hw/msi_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module msi_dispatch (
	input  wire                      clk,
	input  wire                      rst,
	msi_que_if.sink                  que,
	// control levels
	input  wire                      gen_i,
	input  wire msi_irq_pkg::pri_t   thresh_i,
	// vector table lookup
	output msi_irq_pkg::vec_t        lkup_vec_o,
	input  wire msi_irq_pkg::vte_t   lkup_ent_i,
	// core side
	output logic                     irq_o,
	output logic [31:0]              ivect_o,	// handler address
	output logic [2:0]               swstk_o,
	output msi_irq_pkg::pri_t        ipri_o,
	output msi_irq_pkg::vec_t        ivec_o,
	input  wire                      irq_ack_i
);
	import msi_irq_pkg::*;

	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_LOOKUP  = 2'd1;	// table read in flight
	localparam logic [1:0] ST_DELIVER = 2'd2;	// irq held for the core

	logic [1:0] state;
	pri_mask_t  elig;
	pri_t       sel;
	logic       any;
	msi_msg_t   msg_q;	// message popped for this round

	// ============================================================
	// pick the highest eligible queue
	// ============================================================
	always_comb begin
		elig = '0;
		sel  = '0;
		for (int p = 1; p < NPRI; p++)
			elig[p] = que.nonempty[p] && pri_t'(p) > thresh_i;
		for (int p = 1; p < NPRI; p++)
			if (elig[p])
				sel = pri_t'(p);	// later hit is higher priority
	end

	assign any         = |elig;
	assign que.pop     = state == ST_IDLE && any;	// never while irq is up
	assign que.pop_pri = sel;
	assign lkup_vec_o  = que.head.vec;	// entry is ready in ST_LOOKUP

	// ============================================================
	// sequence
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			irq_o <= 1'b0;
		end else begin
			case (state)
			ST_IDLE:
				if (any)
					state <= ST_LOOKUP;
			ST_LOOKUP:
				if (lkup_ent_i.f.ie && gen_i) begin
					irq_o <= 1'b1;
					state <= ST_DELIVER;
				end else
					state <= ST_IDLE;	// disabled, message is dropped
			ST_DELIVER:
				if (irq_ack_i) begin
					irq_o <= 1'b0;
					state <= ST_IDLE;
				end
			default: state <= ST_IDLE;
			endcase
		end
	end

	// core side payload, stable from the rise of irq_o to the ack
	always_ff @(posedge clk) begin
		if (que.pop)
			msg_q <= que.head;
		if (state == ST_LOOKUP) begin
			ivect_o <= lkup_ent_i.f.handler;
			swstk_o <= lkup_ent_i.f.swstk;
			ipri_o  <= msg_q.pri;
			ivec_o  <= msg_q.vec;
		end
	end

endmodule

`default_nettype wire

/* hw/msi_vec_table.sv */
`timescale 1ns/1ps
`default_nettype none

module msi_vec_table (
	input  wire                          clk,
	// register side, one 32-bit half per access
	input  wire                          rw_we_i,
	input  wire msi_bus_pkg::reg_adr_t   rw_adr_i,
	input  wire msi_bus_pkg::reg_dat_t   rw_dat_i,
	output msi_bus_pkg::reg_dat_t        rw_dat_o,
	// dispatcher side, whole entry
	input  wire msi_irq_pkg::vec_t       lkup_vec_i,
	output msi_irq_pkg::vte_t            lkup_ent_o
);
	import msi_irq_pkg::*;

	vte_t mem [NVEC];	// not cleared by reset

	vec_t rw_vec;
	logic rw_half;	// 0 handler word, 1 flags word

	// two words per vector above the table base
	assign rw_vec  = rw_adr_i[6:1];
	assign rw_half = rw_adr_i[0];

	// ============================================================
	// register port
	// ============================================================
	always_ff @(posedge clk) begin
		if (rw_we_i)
			mem[rw_vec].raw[rw_half] <= rw_dat_i;
		rw_dat_o <= mem[rw_vec].raw[rw_half];	// old data on a write
	end

	// ============================================================
	// lookup port
	// ============================================================
	always_ff @(posedge clk)
		lkup_ent_o <= mem[lkup_vec_i];	// one cycle after the address

endmodule

`default_nettype wire

/* hw/msi_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module msi_controller #(
	parameter logic [5:0] CORE_NO   = 6'd5,
	parameter int         QUE_DEPTH = 4
) (
	input  wire                          clk,
	input  wire                          rst,
	// register port
	input  wire                          reg_cs_i,
	input  wire                          reg_we_i,
	input  wire msi_bus_pkg::reg_adr_t   reg_adr_i,
	input  wire msi_bus_pkg::reg_dat_t   reg_dat_i,
	output msi_bus_pkg::reg_dat_t        reg_dat_o,
	output logic                         reg_ack_o,
	// snooped messages
	input  wire                          msg_valid_i,
	input  wire [5:0]                    msg_core_i,
	input  wire msi_irq_pkg::vec_t       msg_vec_i,
	input  wire msi_irq_pkg::pri_t       msg_pri_i,
	// core side
	output logic                         irq_o,
	output logic [31:0]                  ivect_o,
	output logic [2:0]                   swstk_o,
	output msi_irq_pkg::pri_t            ipri_o,
	output msi_irq_pkg::vec_t            ivec_o,
	input  wire                          irq_ack_i
);
	import msi_bus_pkg::*;
	import msi_irq_pkg::*;

	logic      take;	// message accepted this cycle
	vec_t      take_vec;
	pri_mask_t drop;	// accepted into a full queue
	logic      gen;
	pri_t      thresh;
	logic      tbl_we;
	reg_adr_t  tbl_adr;
	reg_dat_t  tbl_wdat, tbl_rdat;
	vec_t      lkup_vec;
	vte_t      lkup_ent;

	msi_que_if que ();

	// ============================================================
	// blocks
	// ============================================================
	msi_regs u_regs (
		.clk(clk), .rst(rst),
		.reg_cs_i(reg_cs_i), .reg_we_i(reg_we_i),
		.reg_adr_i(reg_adr_i), .reg_dat_i(reg_dat_i),
		.reg_dat_o(reg_dat_o), .reg_ack_o(reg_ack_o),
		.take_i(take), .take_vec_i(take_vec), .drop_i(drop),
		.que(que.monitor),
		.gen_o(gen), .thresh_o(thresh),
		.tbl_we_o(tbl_we), .tbl_adr_o(tbl_adr),
		.tbl_dat_o(tbl_wdat), .tbl_dat_i(tbl_rdat)
	);

	msi_queue_bank #(.CORE_NO(CORE_NO), .QUE_DEPTH(QUE_DEPTH)) u_bank (
		.clk(clk), .rst(rst),
		.msg_valid_i(msg_valid_i), .msg_core_i(msg_core_i),
		.msg_vec_i(msg_vec_i), .msg_pri_i(msg_pri_i),
		.take_o(take), .take_vec_o(take_vec), .drop_o(drop),
		.que(que.source)
	);

	msi_dispatch u_disp (
		.clk(clk), .rst(rst),
		.que(que.sink),
		.gen_i(gen), .thresh_i(thresh),
		.lkup_vec_o(lkup_vec), .lkup_ent_i(lkup_ent),
		.irq_o(irq_o), .ivect_o(ivect_o), .swstk_o(swstk_o),
		.ipri_o(ipri_o), .ivec_o(ivec_o), .irq_ack_i(irq_ack_i)
	);

	msi_vec_table u_vtbl (
		.clk(clk),
		.rw_we_i(tbl_we), .rw_adr_i(tbl_adr),
		.rw_dat_i(tbl_wdat), .rw_dat_o(tbl_rdat),
		.lkup_vec_i(lkup_vec), .lkup_ent_o(lkup_ent)
	);

endmodule

`default_nettype wire

/* include/msi_tb_table.svh */
// one row per step: kind, register address (or vector), data word
// data is the write value, the expected read value, a cycle count or a packed message
`ifndef MSI_TB_TABLE_SVH
`define MSI_TB_TABLE_SVH

// row kinds
localparam logic [3:0] K_WR    = 4'd0;	// register write
localparam logic [3:0] K_RD    = 4'd1;	// register read, data is expected
localparam logic [3:0] K_HWR   = 4'd2;	// handler word write, value from the LFSR
localparam logic [3:0] K_TRD   = 4'd3;	// table word read, expected from the model
localparam logic [3:0] K_MSG   = 4'd4;	// adr is the vector, data {core[13:8], pri[2:0]}
localparam logic [3:0] K_EXPI  = 4'd5;	// adr is the vector, data[2:0] the priority
localparam logic [3:0] K_ACK   = 4'd6;
localparam logic [3:0] K_IDLE  = 4'd7;	// data is a cycle count
localparam logic [3:0] K_QUIET = 4'd8;	// idle cycles with irq_o low

localparam int ROW_MAX = 160;

typedef struct packed {
	logic [3:0] kind;
	reg_adr_t   adr;
	reg_dat_t   dat;
} row_t;

row_t rows [ROW_MAX];
int   nrows;

task automatic add_row(input logic [3:0] kind, input reg_adr_t adr, input reg_dat_t dat);
	rows[nrows].kind = kind;
	rows[nrows].adr  = adr;
	rows[nrows].dat  = dat;
	nrows++;
endtask

// word address of one half of a vector's entry
function automatic reg_adr_t entry_adr(input int vec, input int half);
	return REG_VTBL_BASE + reg_adr_t'(2 * vec + half);
endfunction

function automatic reg_dat_t msg_word(input logic [5:0] core, input int pri);
	return {18'd0, core, 5'd0, pri[2:0]};
endfunction

task automatic build_table;
	int i;
	nrows = 0;
	// ============================================================
	// register read-back
	// ============================================================
	add_row(K_WR, REG_CTRL, 32'h1);
	add_row(K_RD, REG_CTRL, 32'h1);
	add_row(K_WR, REG_THRESH, 32'h5);
	add_row(K_RD, REG_THRESH, 32'h5);
	add_row(K_WR, REG_THRESH, 32'h0);
	add_row(K_RD, REG_THRESH, 32'h0);
	add_row(K_RD, REG_EMPTY, 32'h0);
	add_row(K_RD, REG_OVFL, 32'h0);
	add_row(K_RD, REG_PEND_BASE, 32'h0);
	add_row(K_RD, REG_PEND_BASE + 8'd1, 32'h0);
	add_row(K_HWR, entry_adr(9, 0), 32'h0);
	add_row(K_WR, entry_adr(9, 1), 32'h5a5a_5a53);	// reserved bits too, swstk 1
	add_row(K_TRD, entry_adr(9, 0), 32'h0);
	add_row(K_TRD, entry_adr(9, 1), 32'h0);
	add_row(K_HWR, entry_adr(12, 0), 32'h0);
	add_row(K_WR, entry_adr(12, 1), 32'h5);	// swstk 2
	add_row(K_HWR, entry_adr(40, 0), 32'h0);
	add_row(K_WR, entry_adr(40, 1), 32'hf);	// swstk 7
	add_row(K_HWR, entry_adr(33, 0), 32'h0);
	add_row(K_WR, entry_adr(33, 1), 32'h7);
	add_row(K_HWR, entry_adr(17, 0), 32'h0);
	add_row(K_WR, entry_adr(17, 1), 32'h4);	// ie clear
	add_row(K_HWR, entry_adr(18, 0), 32'h0);
	add_row(K_WR, entry_adr(18, 1), 32'h1);
	add_row(K_HWR, entry_adr(7, 0), 32'h0);
	add_row(K_WR, entry_adr(7, 1), 32'hd);
	add_row(K_TRD, entry_adr(40, 0), 32'h0);
	add_row(K_TRD, entry_adr(17, 1), 32'h0);
	for (i = 0; i <= QUE_DEPTH; i++) begin
		add_row(K_HWR, entry_adr(20 + i, 0), 32'h0);
		add_row(K_WR, entry_adr(20 + i, 1), reg_dat_t'(2 * i + 1));	// swstk follows i
	end
	// ============================================================
	// delivery, foreign core and priority 0
	// ============================================================
	add_row(K_MSG, 8'd9, msg_word(CORE_NO, 3));
	add_row(K_EXPI, 8'd9, 32'd3);
	add_row(K_RD, REG_PEND_BASE, 32'h0000_0200);
	add_row(K_ACK, 8'd0, 32'h0);
	add_row(K_QUIET, 8'd0, 32'd4);
	add_row(K_WR, REG_PEND_BASE, 32'h0000_0200);
	add_row(K_RD, REG_PEND_BASE, 32'h0);
	add_row(K_MSG, 8'd9, msg_word(6'd4, 3));	// other core
	add_row(K_MSG, 8'd9, msg_word(CORE_NO, 0));
	add_row(K_QUIET, 8'd0, 32'd8);
	add_row(K_RD, REG_PEND_BASE, 32'h0);
	add_row(K_RD, REG_EMPTY, 32'h0);
	// ============================================================
	// ordering behind a held interrupt
	// ============================================================
	add_row(K_MSG, 8'd9, msg_word(CORE_NO, 3));
	add_row(K_EXPI, 8'd9, 32'd3);
	add_row(K_MSG, 8'd12, msg_word(CORE_NO, 2));
	add_row(K_MSG, 8'd40, msg_word(CORE_NO, 6));
	add_row(K_IDLE, 8'd0, 32'd2);
	add_row(K_RD, REG_EMPTY, 32'h44);
	add_row(K_ACK, 8'd0, 32'h0);
	add_row(K_EXPI, 8'd40, 32'd6);
	add_row(K_ACK, 8'd0, 32'h0);
	add_row(K_EXPI, 8'd12, 32'd2);
	add_row(K_ACK, 8'd0, 32'h0);
	add_row(K_QUIET, 8'd0, 32'd4);
	add_row(K_RD, REG_PEND_BASE, 32'h0000_1200);
	add_row(K_RD, REG_PEND_BASE + 8'd1, 32'h0000_0100);
	add_row(K_WR, REG_PEND_BASE, 32'hffff_ffff);
	add_row(K_WR, REG_PEND_BASE + 8'd1, 32'hffff_ffff);
	add_row(K_RD, REG_PEND_BASE, 32'h0);
	add_row(K_RD, REG_PEND_BASE + 8'd1, 32'h0);
	// ============================================================
	// threshold
	// ============================================================
	add_row(K_WR, REG_THRESH, 32'h4);
	add_row(K_MSG, 8'd33, msg_word(CORE_NO, 4));
	add_row(K_QUIET, 8'd0, 32'd8);
	add_row(K_RD, REG_EMPTY, 32'h10);
	add_row(K_WR, REG_THRESH, 32'h3);
	add_row(K_EXPI, 8'd33, 32'd4);
	add_row(K_ACK, 8'd0, 32'h0);
	add_row(K_WR, REG_THRESH, 32'h0);
	add_row(K_RD, REG_PEND_BASE + 8'd1, 32'h2);
	add_row(K_WR, REG_PEND_BASE + 8'd1, 32'h2);
	// ============================================================
	// entry disabled, then global enable off
	// ============================================================
	add_row(K_MSG, 8'd17, msg_word(CORE_NO, 3));
	add_row(K_QUIET, 8'd0, 32'd8);
	add_row(K_RD, REG_EMPTY, 32'h0);
	add_row(K_RD, REG_PEND_BASE, 32'h0002_0000);
	add_row(K_WR, REG_CTRL, 32'h0);
	add_row(K_MSG, 8'd18, msg_word(CORE_NO, 5));
	add_row(K_QUIET, 8'd0, 32'd8);
	add_row(K_RD, REG_EMPTY, 32'h0);
	add_row(K_RD, REG_PEND_BASE, 32'h0006_0000);
	add_row(K_WR, REG_CTRL, 32'h1);
	add_row(K_WR, REG_PEND_BASE, 32'h0006_0000);
	add_row(K_RD, REG_PEND_BASE, 32'h0);
	// ============================================================
	// overflow of queue 5 behind a held interrupt
	// ============================================================
	add_row(K_MSG, 8'd7, msg_word(CORE_NO, 1));
	add_row(K_EXPI, 8'd7, 32'd1);
	for (i = 0; i <= QUE_DEPTH; i++)
		add_row(K_MSG, reg_adr_t'(20 + i), msg_word(CORE_NO, 5));
	add_row(K_RD, REG_OVFL, 32'h20);
	add_row(K_RD, REG_EMPTY, 32'h20);
	add_row(K_WR, REG_OVFL, 32'h20);
	add_row(K_RD, REG_OVFL, 32'h0);
	add_row(K_ACK, 8'd0, 32'h0);
	for (i = 0; i < QUE_DEPTH; i++) begin
		add_row(K_EXPI, reg_adr_t'(20 + i), 32'd5);
		add_row(K_ACK, 8'd0, 32'h0);
	end
	add_row(K_QUIET, 8'd0, 32'd8);	// the dropped one never shows
	add_row(K_RD, REG_EMPTY, 32'h0);
	// dropped messages still leave their pending bit
	add_row(K_RD, REG_PEND_BASE, 32'h80 | (((32'd1 << (QUE_DEPTH + 1)) - 1) << 20));
endtask

`endif

/* testbench/tb_msi_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_msi_controller;
	import msi_bus_pkg::*;
	import msi_irq_pkg::*;

	localparam logic [5:0] CORE_NO    = 6'd5;
	localparam int         QUE_DEPTH  = 4;
	localparam int         CLK_PERIOD = 100;	// ns
	localparam int         WAIT_BOUND = 16;	// cycles allowed for one row

	logic        clk, rst;
	logic        reg_cs_i, reg_we_i;
	reg_adr_t    reg_adr_i;
	reg_dat_t    reg_dat_i, reg_dat_o;
	logic        reg_ack_o;
	logic        msg_valid_i;
	logic [5:0]  msg_core_i;
	vec_t        msg_vec_i;
	pri_t        msg_pri_i;
	logic        irq_o;
	logic [31:0] ivect_o;
	logic [2:0]  swstk_o;
	pri_t        ipri_o;
	vec_t        ivec_o;
	logic        irq_ack_i;

	vte_t        model [NVEC];	// what the table should hold
	logic [31:0] lfsr;

	`include "msi_tb_table.svh"

	msi_controller #(.CORE_NO(CORE_NO), .QUE_DEPTH(QUE_DEPTH)) UUT (
		.clk(clk), .rst(rst),
		.reg_cs_i(reg_cs_i), .reg_we_i(reg_we_i),
		.reg_adr_i(reg_adr_i), .reg_dat_i(reg_dat_i),
		.reg_dat_o(reg_dat_o), .reg_ack_o(reg_ack_o),
		.msg_valid_i(msg_valid_i), .msg_core_i(msg_core_i),
		.msg_vec_i(msg_vec_i), .msg_pri_i(msg_pri_i),
		.irq_o(irq_o), .ivect_o(ivect_o), .swstk_o(swstk_o),
		.ipri_o(ipri_o), .ivec_o(ivec_o), .irq_ack_i(irq_ack_i)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ============================================================
	// random handler addresses
	// ============================================================
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;	// x^32+x^22+x^2+x+1
	endfunction

	task automatic draw_word(output reg_dat_t w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			w    = {w[30:0], lfsr[0]};
			lfsr = galois_step(lfsr);	// one step per bit
		end
	endtask

	// ============================================================
	// compares
	// ============================================================
	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic dat_compare(input string name, input reg_dat_t got, input reg_dat_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic handler_compare(input string name, input logic [31:0] got, input vte_t ent);
		if (got !== ent.f.handler)
			stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got,
				ent.f.handler));
	endtask

	task automatic stack_compare(input string name, input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic pri_compare(input string name, input pri_t got, input pri_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic vec_compare(input string name, input vec_t got, input vec_t exp);
		if (got !== exp)
			stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	// ============================================================
	// bus actions start and end just after a rising edge
	// ============================================================
	task automatic write_reg(input reg_adr_t adr, input reg_dat_t dat);
		reg_cs_i  = 1'b1;
		reg_we_i  = 1'b1;
		reg_adr_i = adr;
		reg_dat_i = dat;
		@(posedge clk);
		#1;
		reg_cs_i = 1'b0;
		reg_we_i = 1'b0;
		if (reg_ack_o !== 1'b1)
			stop_with_error("reg_ack_o did not follow the write strobe by one cycle");
	endtask

	task automatic read_reg(input reg_adr_t adr, output reg_dat_t dat);
		reg_cs_i  = 1'b1;
		reg_we_i  = 1'b0;
		reg_adr_i = adr;
		@(posedge clk);
		#1;
		reg_cs_i = 1'b0;
		if (reg_ack_o !== 1'b1)
			stop_with_error("reg_ack_o did not follow the read strobe by one cycle");
		dat = reg_dat_o;	// valid with the ack
	endtask

	task automatic send_msg(input logic [5:0] core, input vec_t vec, input pri_t pri);
		msg_valid_i = 1'b1;
		msg_core_i  = core;
		msg_vec_i   = vec;
		msg_pri_i   = pri;
		@(posedge clk);
		#1;
		msg_valid_i = 1'b0;
	endtask

	task automatic expect_irq(input vec_t vec, input pri_t pri);
		int n;
		n = 0;
		while (irq_o !== 1'b1 && n < WAIT_BOUND) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (irq_o !== 1'b1)
			stop_with_error("irq_o did not rise within the wait bound");
		handler_compare("ivect_o", ivect_o, model[vec]);
		stack_compare("swstk_o", swstk_o, model[vec].f.swstk);
		pri_compare("ipri_o", ipri_o, pri);
		vec_compare("ivec_o", ivec_o, vec);
	endtask

	task automatic ack_irq;
		if (irq_o !== 1'b1)
			stop_with_error("irq_o was not held high before irq_ack_i");
		irq_ack_i = 1'b1;
		@(posedge clk);
		#1;
		irq_ack_i = 1'b0;
		if (irq_o !== 1'b0)
			stop_with_error("irq_o stayed high after irq_ack_i");
	endtask

	task automatic watch_quiet(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#1;
			if (irq_o !== 1'b0)
				stop_with_error("irq_o rose although no interrupt was expected");
			if (reg_ack_o !== 1'b0)
				stop_with_error("reg_ack_o was high without a register strobe");
		end
	endtask

	task automatic run_row(input row_t r);
		reg_dat_t got;
		reg_dat_t word;
		case (r.kind)
		K_WR: begin
			if (r.adr >= REG_VTBL_BASE)
				model[r.adr[6:1]].raw[r.adr[0]] = r.dat;
			write_reg(r.adr, r.dat);
		end
		K_RD: begin
			read_reg(r.adr, got);
			dat_compare("reg_dat_o", got, r.dat);
		end
		K_HWR: begin
			draw_word(word);
			model[r.adr[6:1]].raw[0] = word;	// handler half
			write_reg(r.adr, word);
		end
		K_TRD: begin
			read_reg(r.adr, got);
			dat_compare("reg_dat_o", got, model[r.adr[6:1]].raw[r.adr[0]]);
		end
		K_MSG:   send_msg(r.dat[13:8], vec_t'(r.adr), pri_t'(r.dat[2:0]));
		K_EXPI:  expect_irq(vec_t'(r.adr), pri_t'(r.dat[2:0]));
		K_ACK:   ack_irq();
		K_IDLE: begin
			repeat (r.dat) begin
				@(posedge clk);
				#1;
			end
		end
		K_QUIET: watch_quiet(r.dat);
		default: stop_with_error("unknown row kind in the stimulus table");
		endcase
	endtask

	// ============================================================
	// watchdog sized from the table length
	// ============================================================
	initial begin
		#1;
		#(nrows * WAIT_BOUND * CLK_PERIOD);
		stop_with_error("watchdog expired before the stimulus table finished");
	end

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		reg_cs_i    = 1'b0;
		reg_we_i    = 1'b0;
		reg_adr_i   = '0;
		reg_dat_i   = '0;
		msg_valid_i = 1'b0;
		msg_core_i  = '0;
		msg_vec_i   = '0;
		msg_pri_i   = '0;
		irq_ack_i   = 1'b0;
		lfsr        = 32'h17d5_d7d7;
		build_table();
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < nrows; i++)
			run_row(rows[i]);
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hw/msi_bus_pkg.sv
hw/msi_irq_pkg.sv
hw/msi_que_if.sv
hw/msi_regs.sv
hw/msi_queue_bank.sv
hw/msi_dispatch.sv
hw/msi_vec_table.sv
hw/msi_controller.sv
testbench/tb_msi_controller.sv
